// File: source/lsu_map_pkg.sv
/*
 * LSU memory map package
 * Data widths and the address windows of the DCCM and the PIC.
 * Any address outside both windows goes to the external bus.
 */
`default_nettype none

package lsu_map_pkg;

   // Data and address width
   localparam int XLEN       = 32;
   // DMA write data comes in as a full doubleword
   localparam int DMA_DATA_W = 64;
   // Immediate offset from decode
   localparam int OFFSET_W   = 12;

   // **************************************************
   // Address windows, power-of-two sized and aligned
   // **************************************************
   localparam logic [XLEN-1:0] DCCM_BASE = 32'hF004_0000;
   localparam logic [XLEN-1:0] DCCM_SIZE = 32'h0001_0000;

   localparam logic [XLEN-1:0] PIC_BASE  = 32'hF00C_0000;
   localparam logic [XLEN-1:0] PIC_SIZE  = 32'h0000_8000;

endpackage

`default_nettype wire

// File: source/lsu_types_pkg.sv
/*
 * LSU types package
 * Access packet, per-stage payload, flush vector, DMA request
 * and error packet, with the size, region and exception enums.
 */
`default_nettype none

package lsu_types_pkg;

   // Same encoding as the DMA size field
   typedef enum logic [1:0] {
      SZ_BYTE  = 2'd0,
      SZ_HALF  = 2'd1,
      SZ_WORD  = 2'd2,
      SZ_DWORD = 2'd3
   } lsu_size_e;

   typedef enum logic [1:0] {
      REG_DCCM = 2'd0,
      REG_PIC  = 2'd1,
      REG_EXT  = 2'd2
   } lsu_region_e;

   typedef enum logic {
      EXC_MISALIGNED = 1'b0,
      EXC_ACCESS     = 1'b1
   } lsu_exc_e;

   // **************************************************
   // Packets
   // **************************************************
   typedef struct packed {
      logic      valid;
      logic      dma;
      logic      load;
      logic      store;
      logic      unsign;
      lsu_size_e size;
   } lsu_pkt_t;

   // One access as it moves through a stage
   typedef struct packed {
      lsu_pkt_t                       pkt;
      logic [lsu_map_pkg::XLEN-1:0]   addr;
      logic [lsu_map_pkg::XLEN-1:0]   end_addr;
      lsu_region_e                    region;
      logic                           misaligned;
      logic                           access_fault;
      logic [lsu_map_pkg::XLEN-1:0]   store_data;
   } lsu_stage_t;

   typedef struct packed {
      logic dc2_up;
      logic dc3;
      logic dc4;
      logic dc5;
   } lsu_flush_t;

   typedef struct packed {
      logic                               req;
      logic [lsu_map_pkg::XLEN-1:0]       addr;
      lsu_size_e                          size;
      logic                               write;
      logic [lsu_map_pkg::DMA_DATA_W-1:0] wdata;
   } lsu_dma_req_t;

   // inst_type is 1 for a store
   typedef struct packed {
      logic                           exc_valid;
      lsu_exc_e                       exc_type;
      logic                           inst_type;
      logic                           dma_valid;
      logic [lsu_map_pkg::XLEN-1:0]   addr;
   } lsu_error_pkt_t;

endpackage

`default_nettype wire

// File: source/lsu_addrcheck.sv
/*
 * LSU address check
 * Decodes the region of one access and flags misaligned
 * and access faults from its start and end address.
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_addrcheck (
   input  wire  logic [lsu_map_pkg::XLEN-1:0]   start_addr,
   input  wire  logic [lsu_map_pkg::XLEN-1:0]   end_addr,
   input  wire  lsu_types_pkg::lsu_size_e       size,
   output lsu_types_pkg::lsu_region_e           region,
   output logic                                 misaligned,
   output logic                                 access_fault
);

   lsu_types_pkg::lsu_region_e  end_region;
   logic                        unaligned;

   // Windows are aligned to their size, so masking the low bits is enough
   function automatic lsu_types_pkg::lsu_region_e region_of(
      input logic [lsu_map_pkg::XLEN-1:0] a
   );
      if ((a & ~(lsu_map_pkg::DCCM_SIZE - 1)) == lsu_map_pkg::DCCM_BASE) begin
         return lsu_types_pkg::REG_DCCM;
      end
      if ((a & ~(lsu_map_pkg::PIC_SIZE - 1)) == lsu_map_pkg::PIC_BASE) begin
         return lsu_types_pkg::REG_PIC;
      end
      return lsu_types_pkg::REG_EXT;
   endfunction

   assign region     = region_of(start_addr);
   assign end_region = region_of(end_addr);

   // Natural alignment by size
   always_comb begin
      case (size)
         lsu_types_pkg::SZ_HALF:  unaligned = start_addr[0];
         lsu_types_pkg::SZ_WORD:  unaligned = |start_addr[1:0];
         lsu_types_pkg::SZ_DWORD: unaligned = |start_addr[2:0];
         default:                 unaligned = 1'b0;
      endcase
   end

   // **************************************************
   // Faults
   // **************************************************
   // DCCM handles unaligned accesses itself
   assign misaligned = unaligned & (region != lsu_types_pkg::REG_DCCM);

   // Crossing a window edge, or a PIC access that is not a word
   assign access_fault = (region != end_region)
                       | ((region == lsu_types_pkg::REG_PIC) &
                          (size != lsu_types_pkg::SZ_WORD));

endmodule

`default_nettype wire

// File: source/lsu_agu.sv
/*
 * LSU address generation
 * Picks the DMA request or the core access at decode, registers it
 * into dc1, and forms the start and end address of the access.
 * Region and faults come from the address checker.
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_agu (
   input  wire                                      clk,
   input  wire                                      reset,
   input  wire  lsu_types_pkg::lsu_pkt_t            lsu_p,
   input  wire  lsu_types_pkg::lsu_flush_t          flush,
   input  wire  logic [lsu_map_pkg::XLEN-1:0]       rs1,
   input  wire  logic [lsu_map_pkg::OFFSET_W-1:0]   offset,
   input  wire  logic [lsu_map_pkg::XLEN-1:0]       rs2,
   input  wire  lsu_types_pkg::lsu_dma_req_t        dma,
   output lsu_types_pkg::lsu_stage_t                dc1
);

   lsu_types_pkg::lsu_pkt_t                 pkt_d;
   lsu_types_pkg::lsu_pkt_t                 pkt_dc1;
   logic [lsu_map_pkg::XLEN-1:0]            base_d;
   logic [lsu_map_pkg::XLEN-1:0]            base_dc1;
   logic [lsu_map_pkg::OFFSET_W-1:0]        offset_d;
   logic [lsu_map_pkg::OFFSET_W-1:0]        offset_dc1;
   logic [lsu_map_pkg::DMA_DATA_W-1:0]      dma_wdata_shifted;
   logic [lsu_map_pkg::XLEN-1:0]            store_data_d;
   logic [lsu_map_pkg::XLEN-1:0]            store_data_dc1;
   logic [2:0]                              size_span;
   logic [lsu_map_pkg::OFFSET_W:0]          end_offset;
   logic [lsu_map_pkg::XLEN-1:0]            addr_dc1;
   logic [lsu_map_pkg::XLEN-1:0]            end_addr_dc1;
   lsu_types_pkg::lsu_region_e              region_dc1;
   logic                                    misaligned_dc1;
   logic                                    access_fault_dc1;

   // **************************************************
   // Decode stage premux, DMA wins the slot
   // **************************************************
   assign dma_wdata_shifted = dma.wdata >> {dma.addr[2:0], 3'b000};

   always_comb begin
      pkt_d = lsu_p;
      if (dma.req) begin
         pkt_d.dma    = 1'b1;
         pkt_d.load   = ~dma.write;
         pkt_d.store  = dma.write;
         pkt_d.unsign = 1'b0;
         pkt_d.size   = dma.size;
      end
      pkt_d.valid = (lsu_p.valid & ~flush.dc2_up) | dma.req;

      base_d       = dma.req ? dma.addr : rs1;
      offset_d     = dma.req ? '0 : offset;
      store_data_d = dma.req ? dma_wdata_shifted[lsu_map_pkg::XLEN-1:0] : rs2;
   end

   always_ff @(posedge clk) begin
      pkt_dc1        <= pkt_d;
      base_dc1       <= base_d;
      offset_dc1     <= offset_d;
      store_data_dc1 <= store_data_d;
      if (reset) begin
         pkt_dc1.valid <= 1'b0;
      end
   end

   // **************************************************
   // dc1 start and end address
   // **************************************************
   always_comb begin
      case (pkt_dc1.size)
         lsu_types_pkg::SZ_HALF:  size_span = 3'd1;
         lsu_types_pkg::SZ_WORD:  size_span = 3'd3;
         lsu_types_pkg::SZ_DWORD: size_span = 3'd7;
         default:                 size_span = 3'd0;
      endcase
   end

   // Offset plus span stays signed, one bit wider than the offset
   assign end_offset = {offset_dc1[lsu_map_pkg::OFFSET_W-1], offset_dc1}
                     + {{(lsu_map_pkg::OFFSET_W-2){1'b0}}, size_span};

   assign addr_dc1 = base_dc1
      + {{(lsu_map_pkg::XLEN-lsu_map_pkg::OFFSET_W){offset_dc1[lsu_map_pkg::OFFSET_W-1]}},
         offset_dc1};
   assign end_addr_dc1 = base_dc1
      + {{(lsu_map_pkg::XLEN-lsu_map_pkg::OFFSET_W-1){end_offset[lsu_map_pkg::OFFSET_W]}},
         end_offset};

   lsu_addrcheck u_addrcheck (
      .start_addr   (addr_dc1),
      .end_addr     (end_addr_dc1),
      .size         (pkt_dc1.size),
      .region       (region_dc1),
      .misaligned   (misaligned_dc1),
      .access_fault (access_fault_dc1)
   );

   always_comb begin
      dc1.pkt          = pkt_dc1;
      dc1.addr         = addr_dc1;
      dc1.end_addr     = end_addr_dc1;
      dc1.region       = region_dc1;
      dc1.misaligned   = misaligned_dc1;
      dc1.access_fault = access_fault_dc1;
      dc1.store_data   = store_data_dc1;
   end

endmodule

`default_nettype wire

// File: source/lsu_pipe.sv
/*
 * LSU pipeline registers
 * Carries an access from dc1 through dc5, one stage per cycle.
 * Each stage drops a core access when its flush arrives;
 * DMA accesses always run through.
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_pipe (
   input  wire                                clk,
   input  wire                                reset,
   input  wire  lsu_types_pkg::lsu_stage_t    dc1,
   input  wire  lsu_types_pkg::lsu_flush_t    flush,
   output lsu_types_pkg::lsu_stage_t          dc3,
   output lsu_types_pkg::lsu_stage_t          dc5
);

   localparam int FIRST_REG = 2;
   localparam int LAST_REG  = 5;

   // stage[1] is the dc1 input, stage[2..5] the registered stages
   lsu_types_pkg::lsu_stage_t  stage [1:LAST_REG];
   // Flush that kills the access entering stage s
   logic [LAST_REG:FIRST_REG]  kill;

   assign stage[1] = dc1;

   // **************************************************
   // Kill per stage
   // **************************************************
   // dc2_up covers both dc2 and dc3 entry
   assign kill[2] = flush.dc2_up;
   assign kill[3] = flush.dc2_up;
   assign kill[4] = flush.dc3;
   assign kill[5] = flush.dc4;

   for (genvar s = FIRST_REG; s <= LAST_REG; s++) begin : g_stage
      lsu_types_pkg::lsu_stage_t  stage_in;
      lsu_types_pkg::lsu_stage_t  stage_q;

      always_comb begin
         stage_in = stage[s-1];
         stage_in.pkt.valid = stage[s-1].pkt.valid
                            & ~(kill[s] & ~stage[s-1].pkt.dma);
      end

      // Only the valid bit needs reset, the rest is payload
      always_ff @(posedge clk) begin
         stage_q <= stage_in;
         if (reset) begin
            stage_q.pkt.valid <= 1'b0;
         end
      end

      assign stage[s] = stage_q;
   end

   assign dc3 = stage[3];
   assign dc5 = stage[5];

endmodule

`default_nettype wire

// File: source/lsu_load_format.sv
/*
 * LSU load formatting
 * Selects the dc3 load data from the DCCM or the external bus
 * and sign- or zero-extends byte and half loads.
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_load_format (
   input  wire  lsu_types_pkg::lsu_stage_t      dc3,
   input  wire  logic [lsu_map_pkg::XLEN-1:0]   ld_data_dccm,
   input  wire  logic [lsu_map_pkg::XLEN-1:0]   bus_read_data,
   output logic [lsu_map_pkg::XLEN-1:0]         result
);

   logic [lsu_map_pkg::XLEN-1:0]  ld_data;

   // PIC reads come back on the DCCM data path
   assign ld_data = (dc3.region == lsu_types_pkg::REG_EXT) ? bus_read_data : ld_data_dccm;

   always_comb begin
      case (dc3.pkt.size)
         lsu_types_pkg::SZ_BYTE: begin
            result = {{(lsu_map_pkg::XLEN-8){~dc3.pkt.unsign & ld_data[7]}},
                      ld_data[7:0]};
         end
         lsu_types_pkg::SZ_HALF: begin
            result = {{(lsu_map_pkg::XLEN-16){~dc3.pkt.unsign & ld_data[15]}},
                      ld_data[15:0]};
         end
         // word and wider pass as is
         default: begin
            result = ld_data;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: source/lsu_exc.sv
/*
 * LSU exception and commit
 * Builds the dc3 error packet for core accesses with a fault
 * and signals commit of core loads and stores in dc5.
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_exc (
   input  wire  lsu_types_pkg::lsu_stage_t      dc3,
   input  wire  lsu_types_pkg::lsu_stage_t      dc5,
   input  wire  lsu_types_pkg::lsu_flush_t      flush,
   output lsu_types_pkg::lsu_error_pkt_t        error_pkt,
   output logic                                 commit
);

   logic  fault_dc3;

   assign fault_dc3 = dc3.misaligned | dc3.access_fault;

   // **************************************************
   // dc3 error packet
   // **************************************************
   // DMA faults are not reported to the core
   always_comb begin
      error_pkt.exc_valid = fault_dc3 & dc3.pkt.valid & ~dc3.pkt.dma & ~flush.dc3;
      error_pkt.exc_type  = dc3.misaligned ? lsu_types_pkg::EXC_MISALIGNED
                                           : lsu_types_pkg::EXC_ACCESS;
      error_pkt.inst_type = dc3.pkt.store;
      error_pkt.dma_valid = dc3.pkt.dma;
      error_pkt.addr      = dc3.addr;
   end

   // **************************************************
   // dc5 commit
   // **************************************************
   assign commit = dc5.pkt.valid & (dc5.pkt.load | dc5.pkt.store)
                 & ~flush.dc5 & ~dc5.pkt.dma;

endmodule

`default_nettype wire

// File: source/lsu_lsc_ctl.sv
/*
 * LSU control path top
 * Decode to dc5 pipeline of the load/store unit: address generation
 * in dc1, load result and error packet in dc3, store data and
 * commit in dc5.
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_lsc_ctl (
   input  wire                                      clk,
   input  wire                                      reset,
   // Core access in decode
   input  wire  lsu_types_pkg::lsu_pkt_t            lsu_p,
   input  wire  logic [lsu_map_pkg::XLEN-1:0]       rs1,
   input  wire  logic [lsu_map_pkg::OFFSET_W-1:0]   offset,
   input  wire  logic [lsu_map_pkg::XLEN-1:0]       rs2,
   // DMA slave request
   input  wire  lsu_types_pkg::lsu_dma_req_t        dma,
   input  wire  lsu_types_pkg::lsu_flush_t          flush,
   // Load data, valid while the access is in dc3
   input  wire  logic [lsu_map_pkg::XLEN-1:0]       ld_data_dccm,
   input  wire  logic [lsu_map_pkg::XLEN-1:0]       bus_read_data,
   output logic [lsu_map_pkg::XLEN-1:0]             lsu_addr_dc1,
   output logic [lsu_map_pkg::XLEN-1:0]             lsu_result_dc3,
   output lsu_types_pkg::lsu_error_pkt_t            lsu_error_pkt_dc3,
   output logic [lsu_map_pkg::XLEN-1:0]             store_data_dc5,
   output logic                                     lsu_commit_dc5
);

   lsu_types_pkg::lsu_stage_t  dc1;
   lsu_types_pkg::lsu_stage_t  dc3;
   lsu_types_pkg::lsu_stage_t  dc5;

   lsu_agu u_agu (
      .clk    (clk),
      .reset  (reset),
      .lsu_p  (lsu_p),
      .flush  (flush),
      .rs1    (rs1),
      .offset (offset),
      .rs2    (rs2),
      .dma    (dma),
      .dc1    (dc1)
   );

   lsu_pipe u_pipe (
      .clk   (clk),
      .reset (reset),
      .dc1   (dc1),
      .flush (flush),
      .dc3   (dc3),
      .dc5   (dc5)
   );

   lsu_load_format u_load_format (
      .dc3           (dc3),
      .ld_data_dccm  (ld_data_dccm),
      .bus_read_data (bus_read_data),
      .result        (lsu_result_dc3)
   );

   lsu_exc u_exc (
      .dc3       (dc3),
      .dc5       (dc5),
      .flush     (flush),
      .error_pkt (lsu_error_pkt_dc3),
      .commit    (lsu_commit_dc5)
   );

   assign lsu_addr_dc1   = dc1.addr;
   assign store_data_dc5 = dc5.store_data;

endmodule

`default_nettype wire

// File: verif/tb_lsu_lsc_ctl.sv
/*
 * Testbench for the LSU control path
 * Reads one access per row from the test data file, issues one access
 * per cycle and checks the dc1 address, the dc3 load result and error
 * packet, and the dc5 store data and commit against the file.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_lsc_ctl;

   localparam int MAX_ROWS = 64;
   // d plus dc1 to dc5
   localparam int DEPTH    = 6;

   // One row of the data file, every field a whole number of hex digits
   typedef struct packed {
      logic [3:0]                        src;
      logic [3:0]                        kind;
      logic [3:0]                        size;
      logic [3:0]                        unsign;
      logic [3:0]                        flush_stage;
      logic [lsu_map_pkg::XLEN-1:0]      base;
      logic [lsu_map_pkg::OFFSET_W-1:0]  offset;
      logic [lsu_map_pkg::DMA_DATA_W-1:0] wdata;
      logic [lsu_map_pkg::XLEN-1:0]      dccm_data;
      logic [lsu_map_pkg::XLEN-1:0]      bus_data;
      logic [lsu_map_pkg::XLEN-1:0]      exp_addr;
      logic [lsu_map_pkg::XLEN-1:0]      exp_result;
      logic [3:0]                        exp_exc_valid;
      logic [3:0]                        exp_exc_type;
      logic [lsu_map_pkg::XLEN-1:0]      exp_store;
      logic [3:0]                        exp_commit;
   } row_t;

   logic                               clk;
   logic                               reset;
   lsu_types_pkg::lsu_pkt_t            lsu_p;
   logic [lsu_map_pkg::XLEN-1:0]       rs1;
   logic [lsu_map_pkg::OFFSET_W-1:0]   offset;
   logic [lsu_map_pkg::XLEN-1:0]       rs2;
   lsu_types_pkg::lsu_dma_req_t        dma;
   lsu_types_pkg::lsu_flush_t          flush;
   logic [lsu_map_pkg::XLEN-1:0]       ld_data_dccm;
   logic [lsu_map_pkg::XLEN-1:0]       bus_read_data;
   logic [lsu_map_pkg::XLEN-1:0]       lsu_addr_dc1;
   logic [lsu_map_pkg::XLEN-1:0]       lsu_result_dc3;
   lsu_types_pkg::lsu_error_pkt_t      lsu_error_pkt_dc3;
   logic [lsu_map_pkg::XLEN-1:0]       store_data_dc5;
   logic                               lsu_commit_dc5;

   logic [$bits(row_t)-1:0]  mem [0:MAX_ROWS-1];
   row_t                     rows [0:MAX_ROWS-1];
   int                       num_rows;
   int                       cycles = 0;
   int                       timeout_cycles = 0;
   // Row index held in each stage, -1 for a bubble
   int                       pipe_row [0:DEPTH-1];

   lsu_lsc_ctl DUT (
      .clk               (clk),
      .reset             (reset),
      .lsu_p             (lsu_p),
      .rs1               (rs1),
      .offset            (offset),
      .rs2               (rs2),
      .dma               (dma),
      .flush             (flush),
      .ld_data_dccm      (ld_data_dccm),
      .bus_read_data     (bus_read_data),
      .lsu_addr_dc1      (lsu_addr_dc1),
      .lsu_result_dc3    (lsu_result_dc3),
      .lsu_error_pkt_dc3 (lsu_error_pkt_dc3),
      .store_data_dc5    (store_data_dc5),
      .lsu_commit_dc5    (lsu_commit_dc5)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (timeout_cycles > 0 && cycles >= timeout_cycles) begin
         stop_with_failure($sformatf("Timeout, run not done after %0d cycles", cycles));
      end
   end

   // **************************************************
   // Checks
   // **************************************************
   task automatic stop_with_failure(input string what);
      $display("%s", what);
      $display("Something failed");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_addr(input string name, input logic [lsu_map_pkg::XLEN-1:0] expected,
                             input logic [lsu_map_pkg::XLEN-1:0] actual);
      if (actual !== expected) begin
         stop_with_failure($sformatf("** Error %s: expected %h, actual %h",
                                     name, expected, actual));
      end
   endtask

   task automatic check_result(input string name, input logic [lsu_map_pkg::XLEN-1:0] expected,
                               input logic [lsu_map_pkg::XLEN-1:0] actual);
      if (actual !== expected) begin
         stop_with_failure($sformatf("** Error %s: expected %h, actual %h",
                                     name, expected, actual));
      end
   endtask

   task automatic check_error(input string name,
                              input lsu_types_pkg::lsu_error_pkt_t expected,
                              input lsu_types_pkg::lsu_error_pkt_t actual);
      logic bad;
      bad = (actual.exc_valid !== expected.exc_valid)
          | (actual.dma_valid !== expected.dma_valid);
      // Type, kind and address only count with an exception
      if (expected.exc_valid) begin
         bad = bad | (actual !== expected);
      end
      if (bad) begin
         stop_with_failure($sformatf("** Error %s: expected %h, actual %h",
                                     name, expected, actual));
      end
   endtask

   task automatic check_commit(input string name, input bit expected, input bit actual);
      if (actual != expected) begin
         stop_with_failure($sformatf("** Error %s: expected %b, actual %b",
                                     name, expected, actual));
      end
   endtask

   function automatic lsu_types_pkg::lsu_error_pkt_t expected_error(input row_t r);
      lsu_types_pkg::lsu_error_pkt_t e;
      e.exc_valid = r.exp_exc_valid[0];
      e.exc_type  = lsu_types_pkg::lsu_exc_e'(r.exp_exc_type[0]);
      e.inst_type = r.kind[0];
      e.dma_valid = r.src[0];
      e.addr      = r.exp_addr;
      return e;
   endfunction

   // **************************************************
   // Stimulus
   // **************************************************
   task automatic advance_pipe(input int c);
      int s;
      for (s = DEPTH - 1; s > 0; s--) begin
         pipe_row[s] = pipe_row[s-1];
      end
      pipe_row[0] = (c < num_rows) ? c : -1;
   endtask

   task automatic drive_cycle();
      row_t r;
      lsu_p         = '0;
      dma           = '0;
      rs1           = '0;
      offset        = '0;
      rs2           = '0;
      ld_data_dccm  = '0;
      bus_read_data = '0;
      flush         = '0;
      if (pipe_row[0] >= 0) begin
         r = rows[pipe_row[0]];
         if (r.src[0]) begin
            dma.req   = 1'b1;
            dma.addr  = r.base;
            dma.size  = lsu_types_pkg::lsu_size_e'(r.size[1:0]);
            dma.write = r.kind[0];
            dma.wdata = r.wdata;
         end else begin
            lsu_p.valid  = 1'b1;
            lsu_p.load   = ~r.kind[0];
            lsu_p.store  = r.kind[0];
            lsu_p.unsign = r.unsign[0];
            lsu_p.size   = lsu_types_pkg::lsu_size_e'(r.size[1:0]);
         end
         // DMA rows also drive core operands with an inverted base
         // so the DMA request has to override them
         rs1    = r.src[0] ? ~r.base : r.base;
         offset = r.offset;
         rs2    = r.wdata[lsu_map_pkg::XLEN-1:0];
      end
      if (pipe_row[3] >= 0) begin
         r = rows[pipe_row[3]];
         ld_data_dccm  = r.dccm_data;
         bus_read_data = r.bus_data;
         flush.dc3     = (r.flush_stage == 4'd3);
      end
      if (pipe_row[4] >= 0) begin
         flush.dc4 = (rows[pipe_row[4]].flush_stage == 4'd4);
      end
      if (pipe_row[5] >= 0) begin
         flush.dc5 = (rows[pipe_row[5]].flush_stage == 4'd5);
      end
   endtask

   task automatic check_cycle();
      row_t                           r;
      int                             i;
      lsu_types_pkg::lsu_error_pkt_t  no_exc;
      no_exc = '0;
      if (pipe_row[1] >= 0) begin
         i = pipe_row[1];
         r = rows[i];
         check_addr($sformatf("row %0d dc1 address", i), r.exp_addr, lsu_addr_dc1);
      end
      if (pipe_row[3] >= 0) begin
         i = pipe_row[3];
         r = rows[i];
         if (!r.kind[0]) begin
            check_result($sformatf("row %0d load result", i), r.exp_result, lsu_result_dc3);
         end
         check_error($sformatf("row %0d error packet", i), expected_error(r), lsu_error_pkt_dc3);
      end else begin
         check_error("bubble in dc3 error packet", no_exc, lsu_error_pkt_dc3);
      end
      if (pipe_row[5] >= 0) begin
         i = pipe_row[5];
         r = rows[i];
         if (r.kind[0]) begin
            check_result($sformatf("row %0d store data", i), r.exp_store, store_data_dc5);
         end
         check_commit($sformatf("row %0d commit", i), r.exp_commit[0], lsu_commit_dc5);
      end else begin
         check_commit("bubble in dc5 commit", 1'b0, lsu_commit_dc5);
      end
   endtask

   initial begin
      int i;
      int c;
      reset = 1'b1;
      for (i = 0; i < DEPTH; i++) begin
         pipe_row[i] = -1;
      end
      drive_cycle();
      // All ones marks the end of the rows in the file
      for (i = 0; i < MAX_ROWS; i++) begin
         mem[i] = '1;
      end
      $readmemh("verif/lsu_testdata.txt", mem);
      num_rows = 0;
      while (num_rows < MAX_ROWS && mem[num_rows] !== '1) begin
         rows[num_rows] = mem[num_rows];
         num_rows++;
      end
      if (num_rows == 0) begin
         stop_with_failure("No rows could be read from verif/lsu_testdata.txt");
      end
      timeout_cycles = (num_rows + 10) * 2;

      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
      // Last row leaves dc5 DEPTH - 1 cycles after it issues
      for (c = 0; c < num_rows + DEPTH - 1; c++) begin
         advance_pipe(c);
         drive_cycle();
         @(negedge clk);
         check_cycle();
         @(posedge clk);
         #1;
      end
      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
source/lsu_map_pkg.sv
source/lsu_types_pkg.sv
source/lsu_addrcheck.sv
source/lsu_agu.sv
source/lsu_pipe.sv
source/lsu_load_format.sv
source/lsu_exc.sv
source/lsu_lsc_ctl.sv
verif/tb_lsu_lsc_ctl.sv

// File: Makefile
# Verilator build and run of the LSU control path testbench
# Run from the project root, the testbench reads verif/lsu_testdata.txt

.PHONY: simulate clean

simulate:
	verilator --binary --timing -Wno-fatal -f all.f --top-module tb_lsu_lsc_ctl \
		-Mdir obj_dir -o sim_lsu
	./obj_dir/sim_lsu

clean:
	rm -rf obj_dir

// File: verif/lsu_testdata.txt
// src kind size unsign flush _ base _ offset _ wdata hi _ wdata lo _ dccm data _ bus data
//   _ exp addr _ exp result _ exc_valid exc_type _ exp store data _ exp commit
// src 0 core 1 DMA, kind 0 load 1 store, size 0 byte to 3 dword, flush 0 none or stage 3 to 5
// Result is checked for loads only, store data for stores only
00200_F0040000_010_00000000_00000000_11223344_55667788_F0040010_11223344_00_00000000_1
00000_F0040100_FFC_00000000_00000000_123456A5_00000000_F00400FC_FFFFFFA5_00_00000000_1
00010_F0040200_003_00000000_00000000_89ABCDEF_00000000_F0040203_000000EF_00_00000000_1
00100_80000000_002_00000000_00000000_00000000_CAFE8001_80000002_FFFF8001_00_00000000_1
00110_80000010_7FE_00000000_00000000_00000000_1234F00D_8000080E_0000F00D_00_00000000_1
00200_20000000_800_00000000_00000000_DEADBEEF_0BADBEEF_1FFFF800_0BADBEEF_00_00000000_1
00100_F0040001_000_00000000_00000000_00007FFF_FFFFFFFF_F0040001_00007FFF_00_00000000_1
00200_F00C0000_004_00000000_00000000_000000FF_11111111_F00C0004_000000FF_00_00000000_1
00200_80000000_001_00000000_00000000_00000000_44332211_80000001_44332211_10_00000000_1
01100_F00C0000_003_00000000_0000BEEF_00000000_00000000_F00C0003_00000000_10_0000BEEF_1
00000_F00C0010_000_00000000_00000000_00000080_00000000_F00C0010_FFFFFF80_11_00000000_1
00200_F004FFFC_002_00000000_00000000_12345678_00000000_F004FFFE_12345678_11_00000000_1
01200_F0041000_020_00000000_A5A55A5A_00000000_00000000_F0041020_00000000_00_A5A55A5A_1
01000_40000000_0FF_00000000_000000C3_00000000_00000000_400000FF_00000000_00_000000C3_1
10200_F0042000_7FF_00000000_00000000_600DF00D_00000000_F0042000_600DF00D_00_00000000_0
11200_F0042004_010_11223344_55667788_00000000_00000000_F0042004_00000000_00_11223344_0
11100_80000003_000_01234567_89ABCDEF_00000000_00000000_80000003_00000000_00_23456789_0
00203_80000000_002_00000000_00000000_00000000_76543210_80000002_76543210_00_00000000_0
01204_F0043000_000_00000000_5555AAAA_00000000_00000000_F0043000_00000000_00_5555AAAA_0
00104_80000100_001_00000000_00000000_00000000_0000FFFE_80000101_FFFFFFFE_10_00000000_0
11203_F0044000_000_00000000_0F0F0F0F_00000000_00000000_F0044000_00000000_00_0F0F0F0F_0
00205_F0040020_000_00000000_00000000_87654321_00000000_F0040020_87654321_00_00000000_0
10304_F0045000_000_00000000_00000000_13579BDF_00000000_F0045000_13579BDF_00_00000000_0
